// ==== verilog/user_obi_pkg.sv ====
`default_nettype none

// OBI bus shape seen by the user domain subordinates
package user_obi_pkg;

  // --------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------

  localparam int unsigned ObiAddrWidth = 32;
  localparam int unsigned ObiDataWidth = 32;

  // --------------------------------------------------------------------
  // Channel structs
  // --------------------------------------------------------------------

  // Address phase, held stable by the manager until granted
  typedef struct packed {
    logic [ObiAddrWidth-1:0]   addr;
    logic                      we;
    logic [ObiDataWidth/8-1:0] be;
    logic [ObiDataWidth-1:0]   wdata;
  } obi_a_chan_t;

  // Response phase, valid together with rvalid
  typedef struct packed {
    logic [ObiDataWidth-1:0] rdata;
    logic                    err;
  } obi_r_chan_t;

  // Manager to subordinate
  typedef struct packed {
    logic        req;
    obi_a_chan_t a;
  } sbr_obi_req_t;

  // Subordinate to manager, no rready on this bus
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    obi_r_chan_t r;
  } sbr_obi_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/user_map_pkg.sv ====
`default_nettype none

// Address map and register layout of the user domain
package user_map_pkg;

  // --------------------------------------------------------------------
  // Subordinate indices
  // --------------------------------------------------------------------

  localparam int unsigned NumUserSbr = 2;

  typedef logic [$clog2(NumUserSbr)-1:0] user_idx_t;

  // Index 0 doubles as the decoder default
  localparam user_idx_t UserError   = 1'b0;
  localparam user_idx_t UserGpioIrq = 1'b1;

  // --------------------------------------------------------------------
  // Address rules
  // --------------------------------------------------------------------

  // End address is exclusive
  typedef struct packed {
    user_idx_t                             idx;
    logic [user_obi_pkg::ObiAddrWidth-1:0] start_addr;
    logic [user_obi_pkg::ObiAddrWidth-1:0] end_addr;
  } addr_rule_t;

  localparam int unsigned NumUserSbrRules = 1;

  localparam addr_rule_t [NumUserSbrRules-1:0] UserAddrMap = '{
    '{idx: UserGpioIrq, start_addr: 32'h2000_0000, end_addr: 32'h2000_1000}
  };

  // GPIO register offsets within its 4 KiB window
  localparam logic [11:0] GpioRegIn      = 12'h000;
  localparam logic [11:0] GpioRegRiseEn  = 12'h004;
  localparam logic [11:0] GpioRegFallEn  = 12'h008;
  localparam logic [11:0] GpioRegPending = 12'h00C;

  // Read data for any unmapped access
  localparam logic [31:0] ErrRspData = 32'hBADCAB1E;

endpackage

`default_nettype wire

// ==== verilog/user_addr_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

// Address to subordinate index, falls back to the error subordinate
module user_addr_decode (
  input  logic [user_obi_pkg::ObiAddrWidth-1:0] addr_i,
  output user_map_pkg::user_idx_t               idx_o
);

  // --------------------------------------------------------------------
  // Rule match
  // --------------------------------------------------------------------

  always_comb begin
    // Unmatched addresses go to the error subordinate
    idx_o = user_map_pkg::UserError;
    for (int unsigned i = 0; i < user_map_pkg::NumUserSbrRules; i++) begin
      if ((addr_i >= user_map_pkg::UserAddrMap[i].start_addr) &&
          (addr_i <  user_map_pkg::UserAddrMap[i].end_addr)) begin
        idx_o = user_map_pkg::UserAddrMap[i].idx;
      end
    end
  end

  // --------------------------------------------------------------------
  // Static checks on the map
  // --------------------------------------------------------------------

  // Rule table lives in the package, so check it once at elaboration
  for (genvar i = 0; i < user_map_pkg::NumUserSbrRules; i++) begin : gen_rule_chk
    if (user_map_pkg::UserAddrMap[i].start_addr >=
        user_map_pkg::UserAddrMap[i].end_addr) begin : gen_empty
      $error("Address rule %0d is empty", i);
    end
    // Pairwise overlap, half-open intervals
    for (genvar j = i + 1; j < user_map_pkg::NumUserSbrRules; j++) begin : gen_pair
      if ((user_map_pkg::UserAddrMap[i].start_addr <
           user_map_pkg::UserAddrMap[j].end_addr) &&
          (user_map_pkg::UserAddrMap[j].start_addr <
           user_map_pkg::UserAddrMap[i].end_addr)) begin : gen_overlap
        $error("Address rules %0d and %0d overlap", i, j);
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/user_obi_demux.sv ====
`timescale 1ns/10ps
`default_nettype none

// One OBI subordinate port fanned out to the user subordinates
module user_obi_demux (
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  user_map_pkg::user_idx_t    sel_i,
  input  user_obi_pkg::sbr_obi_req_t sbr_req_i,
  output user_obi_pkg::sbr_obi_rsp_t sbr_rsp_o,

  output user_obi_pkg::sbr_obi_req_t [user_map_pkg::NumUserSbr-1:0] mgr_req_o,
  input  user_obi_pkg::sbr_obi_rsp_t [user_map_pkg::NumUserSbr-1:0] mgr_rsp_i
);

  // Index of the request granted last cycle
  user_map_pkg::user_idx_t rsp_idx_q;
  logic                    granted;

  // --------------------------------------------------------------------
  // Request path
  // --------------------------------------------------------------------

  // Address phase goes everywhere, req only to the selected port
  for (genvar i = 0; i < user_map_pkg::NumUserSbr; i++) begin : gen_req
    assign mgr_req_o[i] = '{
      req: sbr_req_i.req && (sel_i == i),
      a:   sbr_req_i.a
    };
  end

  // Handshake completes this cycle
  assign granted = sbr_req_i.req && mgr_rsp_i[sel_i].gnt;

  // --------------------------------------------------------------------
  // Response steering
  // --------------------------------------------------------------------

  // Responses are one cycle behind the grant, so one entry is enough
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_idx_q <= user_map_pkg::UserError;
    end else if (granted) begin
      rsp_idx_q <= sel_i;
    end
  end

  // Grant from the port being addressed now, response from last grant
  assign sbr_rsp_o = '{
    gnt:    mgr_rsp_i[sel_i].gnt,
    rvalid: mgr_rsp_i[rsp_idx_q].rvalid,
    r:      mgr_rsp_i[rsp_idx_q].r
  };

  // --------------------------------------------------------------------
  // Protocol checks
  // --------------------------------------------------------------------

  // Every grant gets its response on the next cycle
  a_rsp_after_gnt : assert property (
    @(posedge clk_i) disable iff (reset_i)
    granted |=> sbr_rsp_o.rvalid
  ) else $error("No rvalid one cycle after grant");

  // Subordinates only answer what this demux granted to them
  for (genvar i = 0; i < user_map_pkg::NumUserSbr; i++) begin : gen_rsp_chk
    a_no_stray_rvalid : assert property (
      @(posedge clk_i) disable iff (reset_i)
      mgr_rsp_i[i].rvalid |-> ($past(granted) && ($past(sel_i) == i))
    ) else $error("Subordinate %0d raised rvalid without a grant", i);
  end

endmodule

`default_nettype wire

// ==== verilog/user_obi_err_sbr.sv ====
`timescale 1ns/10ps
`default_nettype none

// Terminates unmapped accesses with an error response
module user_obi_err_sbr (
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  user_obi_pkg::sbr_obi_req_t obi_req_i,
  output user_obi_pkg::sbr_obi_rsp_t obi_rsp_o
);

  logic rvalid_q;

  // --------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------

  // Always ready, one response per request one cycle later
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= obi_req_i.req;
    end
  end

  // --------------------------------------------------------------------
  // Response
  // --------------------------------------------------------------------

  // Address and write data are dropped, nothing is stored
  // Reads and writes alike get the marker word and err
  assign obi_rsp_o = '{
    gnt:    obi_req_i.req,
    rvalid: rvalid_q,
    r:      '{
      rdata: user_map_pkg::ErrRspData,
      err:   1'b1
    }
  };

endmodule

`default_nettype wire

// ==== verilog/user_gpio_irq.sv ====
`timescale 1ns/10ps
`default_nettype none

// GPIO edge detector with pending bits and a single interrupt line
module user_gpio_irq #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  user_obi_pkg::sbr_obi_req_t obi_req_i,
  output user_obi_pkg::sbr_obi_rsp_t obi_rsp_o,

  input  logic [GpioCount-1:0]       gpio_i,
  output logic                       irq_o
);

  typedef logic [user_obi_pkg::ObiDataWidth-1:0] word_t;

  // Input history and control registers
  logic [GpioCount-1:0] gpio_q;
  logic [GpioCount-1:0] rise_en_q, fall_en_q;
  logic [GpioCount-1:0] pending_q, pending_d;
  logic [GpioCount-1:0] edge_evt, clr_mask;

  // Bus decode
  logic [11:0]          reg_off;
  logic                 sel_in, sel_rise, sel_fall, sel_pend;
  logic                 wr_en;
  word_t                be_mask;
  logic [GpioCount-1:0] wmask, wbits;

  // Response
  logic                 rvalid_q;
  word_t                rdata_d, rdata_q;
  logic                 err_d, err_q;

  // --------------------------------------------------------------------
  // Register decode
  // --------------------------------------------------------------------

  // Word aligned offset inside the 4 KiB window
  assign reg_off  = {obi_req_i.a.addr[11:2], 2'b00};
  assign sel_in   = (reg_off == user_map_pkg::GpioRegIn);
  assign sel_rise = (reg_off == user_map_pkg::GpioRegRiseEn);
  assign sel_fall = (reg_off == user_map_pkg::GpioRegFallEn);
  assign sel_pend = (reg_off == user_map_pkg::GpioRegPending);
  assign wr_en    = obi_req_i.req && obi_req_i.a.we;

  // Byte enables widened to a bit mask
  always_comb begin
    for (int unsigned b = 0; b < user_obi_pkg::ObiDataWidth / 8; b++) begin
      be_mask[8*b +: 8] = {8{obi_req_i.a.be[b]}};
    end
  end

  // Only the implemented GPIO bits
  assign wmask = be_mask[GpioCount-1:0];
  assign wbits = obi_req_i.a.wdata[GpioCount-1:0] & wmask;

  // --------------------------------------------------------------------
  // Edge detection and pending bits
  // --------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    gpio_q <= gpio_i;
  end

  assign edge_evt = (gpio_i & ~gpio_q & rise_en_q) | (~gpio_i & gpio_q & fall_en_q);

  // Write one to clear
  assign clr_mask = (wr_en && sel_pend) ? wbits : '0;

  // New edge is ORed in after the clear so it survives
  assign pending_d = (pending_q & ~clr_mask) | edge_evt;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rise_en_q <= '0;
      fall_en_q <= '0;
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
      if (wr_en && sel_rise) begin
        rise_en_q <= (rise_en_q & ~wmask) | wbits;
      end
      if (wr_en && sel_fall) begin
        fall_en_q <= (fall_en_q & ~wmask) | wbits;
      end
    end
  end

  assign irq_o = |pending_q;

  // --------------------------------------------------------------------
  // Read data and response
  // --------------------------------------------------------------------

  // Bits above GpioCount come back as zero
  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    unique case (1'b1)
      sel_in:   rdata_d = word_t'(gpio_i);
      sel_rise: rdata_d = word_t'(rise_en_q);
      sel_fall: rdata_d = word_t'(fall_en_q);
      sel_pend: rdata_d = word_t'(pending_q);
      default:  err_d   = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= obi_req_i.req;
    end
  end

  // Payload captured at the grant
  always_ff @(posedge clk_i) begin
    if (obi_req_i.req) begin
      rdata_q <= rdata_d;
      err_q   <= err_d;
    end
  end

  assign obi_rsp_o = '{
    gnt:    obi_req_i.req,
    rvalid: rvalid_q,
    r:      '{rdata: rdata_q, err: err_q}
  };

  // --------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------

  if ((GpioCount == 0) || (GpioCount > user_obi_pkg::ObiDataWidth)) begin : gen_cnt_chk
    $error("GpioCount must be between 1 and the data width");
  end

endmodule

`default_nettype wire

// ==== verilog/user_domain.sv ====
`timescale 1ns/10ps
`default_nettype none

// User domain top, OBI subordinate side only
module user_domain #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                       clk_i,
  input  logic                       reset_i,

  // From the core domain manager
  input  user_obi_pkg::sbr_obi_req_t user_sbr_obi_req_i,
  output user_obi_pkg::sbr_obi_rsp_t user_sbr_obi_rsp_o,

  input  logic [GpioCount-1:0]       gpio_in_sync_i,
  output logic                       irq_o
);

  // --------------------------------------------------------------------
  // Subordinate buses
  // --------------------------------------------------------------------

  // One bus per subordinate, indexed by the map package
  user_obi_pkg::sbr_obi_req_t [user_map_pkg::NumUserSbr-1:0] all_user_sbr_obi_req;
  user_obi_pkg::sbr_obi_rsp_t [user_map_pkg::NumUserSbr-1:0] all_user_sbr_obi_rsp;

  user_map_pkg::user_idx_t user_idx;

  // --------------------------------------------------------------------
  // Decode and demux
  // --------------------------------------------------------------------

  user_addr_decode i_addr_decode (
    .addr_i ( user_sbr_obi_req_i.a.addr ),
    .idx_o  ( user_idx                  )
  );

  user_obi_demux i_obi_demux (
    .clk_i     ( clk_i                ),
    .reset_i   ( reset_i              ),
    .sel_i     ( user_idx             ),
    .sbr_req_i ( user_sbr_obi_req_i   ),
    .sbr_rsp_o ( user_sbr_obi_rsp_o   ),
    .mgr_req_o ( all_user_sbr_obi_req ),
    .mgr_rsp_i ( all_user_sbr_obi_rsp )
  );

  // --------------------------------------------------------------------
  // Subordinates
  // --------------------------------------------------------------------

  // Catches everything outside the map
  user_obi_err_sbr i_user_err (
    .clk_i     ( clk_i                                            ),
    .reset_i   ( reset_i                                          ),
    .obi_req_i ( all_user_sbr_obi_req[user_map_pkg::UserError]    ),
    .obi_rsp_o ( all_user_sbr_obi_rsp[user_map_pkg::UserError]    )
  );

  user_gpio_irq #(
    .GpioCount ( GpioCount )
  ) i_gpio_irq (
    .clk_i     ( clk_i                                            ),
    .reset_i   ( reset_i                                          ),
    .obi_req_i ( all_user_sbr_obi_req[user_map_pkg::UserGpioIrq]  ),
    .obi_rsp_o ( all_user_sbr_obi_rsp[user_map_pkg::UserGpioIrq]  ),
    .gpio_i    ( gpio_in_sync_i                                   ),
    .irq_o     ( irq_o                                            )
  );

endmodule

`default_nettype wire

// ==== sim/tb_user_domain.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_user_domain;

  localparam int unsigned gpio_count = 16;
  localparam time         clk_period = 20ns;
  localparam time         drive_dly  = 2ns;
  localparam int          max_wait   = 10;
  localparam int          num_b2b    = 20;
  // Cycle budgets of reset and the five tests
  localparam int          budget_cycles = 4 + 10 + 80 + 90 + 70 + 30;

  // GPIO window and error word from the address map
  localparam logic [31:0] gpio_base = 32'h2000_0000;
  localparam logic [31:0] gpio_end  = 32'h2000_1000;
  localparam logic [31:0] err_word  = 32'hBADC_AB1E;
  localparam logic [31:0] gpio_mask = (32'd1 << gpio_count) - 1;

  logic                       clk;
  logic                       reset;
  user_obi_pkg::sbr_obi_req_t obi_req;
  user_obi_pkg::sbr_obi_rsp_t obi_rsp;
  logic [gpio_count-1:0]      gpio_in;
  logic                       irq;

  logic [31:0] lfsr_state = 32'h0207_8e0a;
  int          checks     = 0;
  int          errors     = 0;
  int          errs_before;

  // Reference copies of the enable registers
  logic [31:0] rise_model;
  logic [31:0] fall_model;

  user_domain #(
    .GpioCount ( gpio_count )
  ) dut0 (
    .clk_i              ( clk     ),
    .reset_i            ( reset   ),
    .user_sbr_obi_req_i ( obi_req ),
    .user_sbr_obi_rsp_o ( obi_rsp ),
    .gpio_in_sync_i     ( gpio_in ),
    .irq_o              ( irq     )
  );

  // ----------------------------------------------------------------------
  // Clock and watchdog
  // ----------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Twice the summed budgets
  initial begin
    #(2 * budget_cycles * clk_period);
    $display("Watchdog expired, the tests did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return v;
  endfunction

  // Byte enables select which bytes of wdata land
  function automatic logic [31:0] merge_be(input logic [31:0] old, input logic [31:0] wdata,
                                           input logic [3:0] be);
    logic [31:0] v;
    v = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        v[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return v & gpio_mask;
  endfunction

  function automatic logic in_gpio_window(input logic [31:0] addr);
    return (addr >= gpio_base) && (addr < gpio_end);
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  // Expected response of a GPIO access, updates the enable copies on writes
  task automatic gpio_expect(input logic [11:0] off, input logic we, input logic [3:0] be,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
    rdata = '0;
    err   = 1'b0;
    case (off)
      12'h000: rdata = 32'(gpio_in);
      12'h004: rdata = rise_model;
      12'h008: rdata = fall_model;
      // Inputs are held while this is used, so nothing is pending
      12'h00C: rdata = '0;
      default: err = 1'b1;
    endcase
    if (we && (off == 12'h004)) begin
      rise_model = merge_be(rise_model, wdata, be);
    end
    if (we && (off == 12'h008)) begin
      fall_model = merge_be(fall_model, wdata, be);
    end
  endtask

  task automatic set_gpio(input logic [gpio_count-1:0] value);
    @(posedge clk);
    #drive_dly;
    gpio_in = value;
  endtask

  // ----------------------------------------------------------------------
  // Bus tasks
  // ----------------------------------------------------------------------

  // Ends at the negedge where the response was sampled
  task automatic obi_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int n;
    @(posedge clk);
    #drive_dly;
    obi_req = '{req: 1'b1, a: '{addr: addr, we: we, be: be, wdata: wdata}};
    n = 0;
    @(negedge clk);
    while (!obi_rsp.gnt && (n < max_wait)) begin
      @(negedge clk);
      n++;
    end
    if (!obi_rsp.gnt) begin
      errors++;
      $display("No grant for the request to 0x%08h", addr);
    end
    @(posedge clk);
    #drive_dly;
    obi_req.req = 1'b0;
    n = 0;
    @(negedge clk);
    while (!obi_rsp.rvalid && (n < max_wait)) begin
      @(negedge clk);
      n++;
    end
    if (!obi_rsp.rvalid) begin
      errors++;
      $display("No response for the request to 0x%08h", addr);
    end
    rdata = obi_rsp.r.rdata;
    err   = obi_rsp.r.err;
  endtask

  task automatic obi_write(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata, output logic err);
    logic [31:0] rdata;
    obi_access(1'b1, addr, be, wdata, rdata, err);
  endtask

  task automatic obi_read(input logic [31:0] addr, output logic [31:0] rdata,
                          output logic err);
    obi_access(1'b0, addr, 4'hF, '0, rdata, err);
  endtask

  task automatic read_check(input logic [31:0] addr, input logic [31:0] exp_rdata,
                            input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    obi_read(addr, rdata, err);
    check_eq($sformatf("rdata of 0x%08h", addr), rdata, exp_rdata);
    check_eq($sformatf("err of 0x%08h", addr), err, exp_err);
  endtask

  // Register write that must not error
  task automatic write_reg(input logic [11:0] off, input logic [3:0] be,
                           input logic [31:0] wdata);
    logic [31:0] exp_rdata;
    logic        exp_err;
    logic        err;
    gpio_expect(off, 1'b1, be, wdata, exp_rdata, exp_err);
    obi_write(gpio_base + off, be, wdata, err);
    check_eq($sformatf("err of write 0x%03h", off), err, 1'b0);
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------

  task automatic reset_state();
    repeat (5) begin
      @(negedge clk);
      check_eq("irq_o", irq, 1'b0);
      check_eq("rvalid", obi_rsp.rvalid, 1'b0);
    end
  endtask

  task automatic error_sbr_access();
    logic err;
    // Low bits hit RISE_EN and FALL_EN if misrouted
    obi_write(32'h3000_0004, 4'hF, 32'hFFFF_FFFF, err);
    check_eq("err of write 0x30000004", err, 1'b1);
    obi_write(gpio_end + 32'h8, 4'hF, 32'hFFFF_FFFF, err);
    check_eq("err of write past window", err, 1'b1);
    read_check(32'h0000_0000, err_word, 1'b1);
    read_check(32'h1FFF_FFFC, err_word, 1'b1);
    read_check(gpio_end, err_word, 1'b1);
    read_check(32'hFFFF_FFFC, err_word, 1'b1);
    read_check(gpio_base + 32'h4, 32'h0, 1'b0);
    read_check(gpio_base + 32'h8, 32'h0, 1'b0);
  endtask

  task automatic register_access();
    logic [31:0] gin;
    // IN first, enables are still zero
    gin = rand_bits(gpio_count);
    set_gpio(gin[gpio_count-1:0]);
    read_check(gpio_base, gin, 1'b0);
    write_reg(12'h004, 4'b0001, 32'hFFFF_FFFF);
    write_reg(12'h004, 4'b0010, 32'h1234_5678);
    write_reg(12'h008, 4'b1110, 32'hA5A5_A5A5);
    write_reg(12'h008, 4'b0001, 32'h0000_003C);
    read_check(gpio_base + 32'h4, 32'h0000_56FF, 1'b0);
    read_check(gpio_base + 32'h8, 32'h0000_A53C, 1'b0);
    // Unused offsets
    read_check(gpio_base + 32'h10, 32'h0, 1'b1);
    read_check(gpio_base + 32'hFFC, 32'h0, 1'b1);
  endtask

  task automatic edge_interrupts();
    logic [gpio_count-1:0] g;
    write_reg(12'h004, 4'hF, 32'h0);
    write_reg(12'h008, 4'hF, 32'h0);
    g    = gpio_in;
    g[3] = 1'b0;
    g[9] = 1'b1;
    set_gpio(g);
    // Rising on bit 3, falling on bit 9
    write_reg(12'h004, 4'hF, 32'h0000_0008);
    write_reg(12'h008, 4'hF, 32'h0000_0200);
    read_check(gpio_base + 32'hC, 32'h0, 1'b0);
    check_eq("irq_o", irq, 1'b0);
    set_gpio(~g);
    // Pending bits only set on the next rising edge
    @(negedge clk);
    check_eq("irq_o", irq, 1'b0);
    @(negedge clk);
    check_eq("irq_o", irq, 1'b1);
    read_check(gpio_base + 32'hC, 32'h0000_0208, 1'b0);
    write_reg(12'h00C, 4'hF, 32'hFFFF_FFFF);
    check_eq("irq_o", irq, 1'b0);
    read_check(gpio_base + 32'hC, 32'h0, 1'b0);
  endtask

  // Even slots go to the GPIO block, odd slots to unmapped addresses
  task automatic back_to_back();
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_rdata [num_b2b];
    logic        exp_err   [num_b2b];
    logic        is_read   [num_b2b];
    logic [11:0] off;
    logic [3:0]  be;
    logic        we;
    for (int k = 0; k <= num_b2b; k++) begin
      @(posedge clk);
      #drive_dly;
      if (k < num_b2b) begin
        we    = rand_bits(1);
        be    = rand_bits(4);
        wdata = rand_bits(32);
        if ((k % 2) == 0) begin
          off  = 12'(rand_bits(3) << 2);
          addr = gpio_base + off;
          gpio_expect(off, we, be, wdata, exp_rdata[k], exp_err[k]);
        end else begin
          addr = rand_bits(32);
          if (in_gpio_window(addr)) begin
            addr = addr ^ 32'h8000_0000;
          end
          exp_rdata[k] = err_word;
          exp_err[k]   = 1'b1;
        end
        is_read[k] = !we;
        obi_req = '{req: 1'b1, a: '{addr: addr, we: we, be: be, wdata: wdata}};
      end else begin
        obi_req.req = 1'b0;
      end
      @(negedge clk);
      if (k < num_b2b) begin
        check_eq($sformatf("gnt of request %0d", k), obi_rsp.gnt, 1'b1);
      end
      if (k == 0) begin
        check_eq("rvalid before first grant", obi_rsp.rvalid, 1'b0);
      end else begin
        check_eq($sformatf("rvalid of request %0d", k - 1), obi_rsp.rvalid, 1'b1);
        check_eq($sformatf("err of request %0d", k - 1), obi_rsp.r.err, exp_err[k-1]);
        if (is_read[k-1]) begin
          check_eq($sformatf("rdata of request %0d", k - 1), obi_rsp.r.rdata,
                   exp_rdata[k-1]);
        end
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    $display("test %-18s errors %0d", name, errors - errs_at_start);
  endtask

  // ----------------------------------------------------------------------
  // Sequence
  // ----------------------------------------------------------------------

  initial begin
    reset      = 1'b1;
    obi_req    = '0;
    gpio_in    = '0;
    rise_model = '0;
    fall_model = '0;
    repeat (4) @(posedge clk);
    #drive_dly;
    reset = 1'b0;

    errs_before = errors;
    reset_state();
    report_test("reset state", errs_before);
    errs_before = errors;
    error_sbr_access();
    report_test("error subordinate", errs_before);
    errs_before = errors;
    register_access();
    report_test("register access", errs_before);
    errs_before = errors;
    edge_interrupts();
    report_test("edge interrupts", errs_before);
    errs_before = errors;
    back_to_back();
    report_test("back to back", errs_before);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== user_domain.f ====
verilog/user_obi_pkg.sv
verilog/user_map_pkg.sv
verilog/user_addr_decode.sv
verilog/user_obi_demux.sv
verilog/user_obi_err_sbr.sv
verilog/user_gpio_irq.sv
verilog/user_domain.sv
sim/tb_user_domain.sv

// ==== Bender.yml ====
package:
  name: user_domain

sources:
  - verilog/user_obi_pkg.sv
  - verilog/user_map_pkg.sv
  - verilog/user_addr_decode.sv
  - verilog/user_obi_demux.sv
  - verilog/user_obi_err_sbr.sv
  - verilog/user_gpio_irq.sv
  - verilog/user_domain.sv
  - target: test
    files:
      - sim/tb_user_domain.sv
